//--- Makefile
VERILATOR ?= verilator
TOP       ?= lrelu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "overrides: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "test: FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test: FAIL, run ended without a result"; exit 1; \
	else \
	  echo "test: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
+incdir+hdl
hdl/lrelu_cfg_pkg.sv
hdl/lrelu_data_pkg.sv
hdl/lrelu_cfg_wr_if.sv
hdl/lrelu_config_loader.sv
hdl/lrelu_coef_ram.sv
hdl/lrelu_tag_pipe.sv
hdl/lrelu_unit_pipe.sv
hdl/lrelu_engine.sv
verif/lrelu_tb.sv

//--- hdl/lrelu_cfg_pkg.sv
`include "lrelu_macros.svh"

package lrelu_cfg_pkg;

  // write targets of the config stream, in load order
  localparam logic [1:0] SLOT_D = 2'd0;
  localparam logic [1:0] SLOT_A = 2'd1;
  localparam logic [1:0] SLOT_B = 2'd2;

  // address width of a coefficient memory
  localparam int CFG_ADDR_W = (`LRELU_DEPTH > 1) ? $clog2(`LRELU_DEPTH) : 1;

  // last entry, where the write address and read pointers wrap
  localparam logic [CFG_ADDR_W-1:0] ADDR_LAST = CFG_ADDR_W'(`LRELU_DEPTH - 1);

endpackage

//--- hdl/lrelu_cfg_wr_if.sv
`timescale 1ns/1ps
`include "lrelu_macros.svh"

interface lrelu_cfg_wr_if import lrelu_cfg_pkg::*; ();

  logic                    wr_en;
  logic [1:0]              slot;     // one of SLOT_D, SLOT_A, SLOT_B
  logic [CFG_ADDR_W-1:0]   addr;
  logic [`LRELU_W_CFG-1:0] data;
  logic                    restart;  // rewinds read pointers

  modport loader (
    output wr_en,
    output slot,
    output addr,
    output data,
    output restart
  );

  modport sink (
    input wr_en,
    input slot,
    input addr,
    input data,
    input restart
  );

endinterface

//--- hdl/lrelu_coef_ram.sv
`timescale 1ns/1ps
`include "lrelu_macros.svh"

module lrelu_coef_ram import lrelu_cfg_pkg::*; #(
  parameter logic [1:0] SLOT = SLOT_A
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clken,
  lrelu_cfg_wr_if.sink            wr,
  input  logic                    rd_adv,
  output logic [`LRELU_W_CFG-1:0] coef
);

  logic [`LRELU_W_CFG-1:0] mem     [`LRELU_DEPTH];
  logic [`LRELU_W_CFG-1:0] rd_pipe [`LRELU_RAM_LAT];
  logic [CFG_ADDR_W-1:0]   rd_ptr;

  always_ff @(posedge clk) begin
    if (clken && wr.wr_en && wr.slot == SLOT)
      mem[wr.addr] <= wr.data;
  end

  // one entry per accepted beat, wraps at the last channel
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (clken) begin
      if (wr.restart)
        rd_ptr <= '0;
      else if (rd_adv)
        rd_ptr <= (rd_ptr == ADDR_LAST) ? '0 : rd_ptr + 1'b1;
    end
  end

  // registered read, entry for the beat shows up RAM_LAT cycles on
  always_ff @(posedge clk) begin
    if (clken) begin
      rd_pipe[0] <= mem[rd_ptr];
      for (int i = 1; i < `LRELU_RAM_LAT; i++)
        rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign coef = rd_pipe[`LRELU_RAM_LAT-1];

endmodule

//--- hdl/lrelu_config_loader.sv
`timescale 1ns/1ps
`include "lrelu_macros.svh"

module lrelu_config_loader import lrelu_cfg_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clken,
  input  logic                    cfg_valid,
  input  logic [`LRELU_W_CFG-1:0] cfg_data,
  input  logic                    cfg_restart,
  lrelu_cfg_wr_if.loader          wr,
  output logic [`LRELU_W_CFG-1:0] d_coef
);

  logic [1:0]            slot;
  logic [1:0]            slot_next;
  logic [CFG_ADDR_W-1:0] addr;
  logic [CFG_ADDR_W-1:0] addr_next;

  // D once, then DEPTH beats of A, then DEPTH beats of B
  always_comb begin
    slot_next = slot;
    addr_next = addr + 1'b1;
    case (slot)
      SLOT_D: begin
        slot_next = SLOT_A;
        addr_next = '0;
      end
      SLOT_A: begin
        if (addr == ADDR_LAST) begin
          slot_next = SLOT_B;
          addr_next = '0;
        end
      end
      SLOT_B: begin
        if (addr == ADDR_LAST) begin
          slot_next = SLOT_D;
          addr_next = '0;
        end
      end
      default: begin
        slot_next = SLOT_D;   // unused code, back to start
        addr_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slot <= SLOT_D;
      addr <= '0;
    end else if (clken) begin
      if (cfg_restart) begin
        slot <= SLOT_D;
        addr <= '0;
      end else if (cfg_valid) begin
        slot <= slot_next;
        addr <= addr_next;
      end
    end
  end

  // beat stamped with slot and address, lands one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      wr.wr_en   <= 1'b0;
      wr.restart <= 1'b0;
    end else if (clken) begin
      wr.wr_en   <= cfg_valid & ~cfg_restart;  // restart drops a colliding beat
      wr.restart <= cfg_restart;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      wr.slot <= slot;
      wr.addr <= addr;
      wr.data <= cfg_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      d_coef <= '0;
    else if (clken && wr.wr_en && wr.slot == SLOT_D)
      d_coef <= wr.data;
  end

endmodule

//--- hdl/lrelu_data_pkg.sv
`include "lrelu_macros.svh"

package lrelu_data_pkg;

  localparam int OUT_MAX = 2 ** (`LRELU_W_OUT - 1) - 1;
  localparam int OUT_MIN = -OUT_MAX - 1;

  // data word times a Q8.8 coefficient, back to integer scale
  function automatic logic signed [31:0] mul_q8(
    input logic signed [31:0]             x,
    input logic signed [`LRELU_W_CFG-1:0] k
  );
    logic signed [31+`LRELU_W_CFG:0] p;
    p = x * k;
    return 32'(p >>> `LRELU_FRAC);
  endfunction

  // clamp to the signed output range
  function automatic logic signed [`LRELU_W_OUT-1:0] sat_out(
    input logic signed [31:0] v
  );
    if (v > OUT_MAX)
      return `LRELU_W_OUT'(OUT_MAX);
    else if (v < OUT_MIN)
      return `LRELU_W_OUT'(OUT_MIN);
    return v[`LRELU_W_OUT-1:0];
  endfunction

endpackage

//--- hdl/lrelu_engine.sv
`timescale 1ns/1ps
`include "lrelu_macros.svh"

module lrelu_engine import lrelu_cfg_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 clken,
  input  logic                                 s_valid,
  input  logic [`LRELU_UNITS*`LRELU_W_IN-1:0]  s_data,
  input  logic [`LRELU_W_TAG:0]                s_user,
  output logic                                 m_valid,
  output logic [`LRELU_UNITS*`LRELU_W_OUT-1:0] m_data,
  output logic [`LRELU_W_TAG-1:0]              m_user,
  input  logic                                 cfg_valid,
  input  logic [`LRELU_W_CFG-1:0]              cfg_data,
  input  logic                                 cfg_restart
);

  logic [`LRELU_W_CFG-1:0] a_coef;
  logic [`LRELU_W_CFG-1:0] b_coef;
  logic [`LRELU_W_CFG-1:0] d_coef;
  logic                    leaky_s3;

  lrelu_cfg_wr_if cfg_wr ();

  lrelu_config_loader i_loader (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .cfg_valid   (cfg_valid),
    .cfg_data    (cfg_data),
    .cfg_restart (cfg_restart),
    .wr          (cfg_wr.loader),
    .d_coef      (d_coef)
  );

  // both memories step together, all lanes share one entry per beat
  lrelu_coef_ram #(
    .SLOT (SLOT_A)
  ) i_ram_a (
    .clk    (clk),
    .rst    (rst),
    .clken  (clken),
    .wr     (cfg_wr.sink),
    .rd_adv (s_valid),
    .coef   (a_coef)
  );

  lrelu_coef_ram #(
    .SLOT (SLOT_B)
  ) i_ram_b (
    .clk    (clk),
    .rst    (rst),
    .clken  (clken),
    .wr     (cfg_wr.sink),
    .rd_adv (s_valid),
    .coef   (b_coef)
  );

  lrelu_tag_pipe i_tag_pipe (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .s_valid  (s_valid),
    .s_user   (s_user),
    .leaky_s3 (leaky_s3),
    .m_valid  (m_valid),
    .m_user   (m_user)
  );

  for (genvar u = 0; u < `LRELU_UNITS; u++) begin : g_unit
    lrelu_unit_pipe i_unit (
      .clk    (clk),
      .clken  (clken),
      .x      (s_data[u*`LRELU_W_IN +: `LRELU_W_IN]),
      .a_coef (a_coef),
      .b_coef (b_coef),
      .d_coef (d_coef),
      .leaky  (leaky_s3),
      .y      (m_data[u*`LRELU_W_OUT +: `LRELU_W_OUT])
    );
  end

endmodule

//--- hdl/lrelu_macros.svh
`ifndef LRELU_MACROS_SVH
`define LRELU_MACROS_SVH

// lanes and word widths
`define LRELU_UNITS    4
`define LRELU_W_IN     16
`define LRELU_W_OUT    8
`define LRELU_W_CFG    16   // two 8-bit members per config beat
`define LRELU_W_TAG    3

// channels cycled by the coefficient memories
`define LRELU_DEPTH    3

// Q8.8 coefficients
`define LRELU_FRAC     8
`define LRELU_ONE      256
`define LRELU_ALPHA    26   // 0.1 rounded

// pipeline timing in enabled cycles
`define LRELU_RAM_LAT  2
`define LRELU_LATENCY  5

`endif

//--- hdl/lrelu_tag_pipe.sv
`timescale 1ns/1ps
`include "lrelu_macros.svh"

module lrelu_tag_pipe (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clken,
  input  logic                    s_valid,
  input  logic [`LRELU_W_TAG:0]   s_user,    // bit 0 leaky, rest tag
  output logic                    leaky_s3,
  output logic                    m_valid,
  output logic [`LRELU_W_TAG-1:0] m_user
);

  // flag is consumed by the leaky stage, right after alignment and affine
  localparam int LEAKY_STAGES = `LRELU_RAM_LAT + 1;

  logic [`LRELU_LATENCY-1:0] valid_q;
  logic [LEAKY_STAGES-1:0]   leaky_q;
  logic [`LRELU_W_TAG-1:0]   tag_q [`LRELU_LATENCY];

  always_ff @(posedge clk) begin
    if (rst)
      valid_q <= '0;
    else if (clken)
      valid_q <= {valid_q[`LRELU_LATENCY-2:0], s_valid};
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      leaky_q  <= {leaky_q[LEAKY_STAGES-2:0], s_user[0]};
      tag_q[0] <= s_user[`LRELU_W_TAG:1];
      for (int i = 1; i < `LRELU_LATENCY; i++)
        tag_q[i] <= tag_q[i-1];
    end
  end

  assign leaky_s3 = leaky_q[LEAKY_STAGES-1];
  assign m_valid  = valid_q[`LRELU_LATENCY-1];
  assign m_user   = tag_q[`LRELU_LATENCY-1];

endmodule

//--- hdl/lrelu_unit_pipe.sv
`timescale 1ns/1ps
`include "lrelu_macros.svh"

module lrelu_unit_pipe import lrelu_data_pkg::*; (
  input  logic                           clk,
  input  logic                           clken,
  input  logic signed [`LRELU_W_IN-1:0]  x,
  input  logic signed [`LRELU_W_CFG-1:0] a_coef,
  input  logic signed [`LRELU_W_CFG-1:0] b_coef,
  input  logic signed [`LRELU_W_CFG-1:0] d_coef,
  input  logic                           leaky,
  output logic signed [`LRELU_W_OUT-1:0] y
);

  logic signed [`LRELU_W_IN-1:0]  x_d [`LRELU_RAM_LAT];
  logic signed [31:0]             y1;
  logic signed [31:0]             y2;
  logic signed [`LRELU_W_CFG-1:0] c_coef;

  // alpha slope only on the negative side of flagged beats
  assign c_coef = (leaky && y1 < 0) ? `LRELU_W_CFG'(`LRELU_ALPHA)
                                    : `LRELU_W_CFG'(`LRELU_ONE);

  always_ff @(posedge clk) begin
    if (clken) begin
      x_d[0] <= x;  // wait for the memory read
      for (int i = 1; i < `LRELU_RAM_LAT; i++)
        x_d[i] <= x_d[i-1];

      y1 <= mul_q8(x_d[`LRELU_RAM_LAT-1], a_coef) + b_coef;  // affine
      y2 <= mul_q8(y1, c_coef) + d_coef;                      // leaky relu
      y  <= sat_out(y2);
    end
  end

endmodule

//--- verif/lrelu_tb.sv
`timescale 1ns/1ps
`include "lrelu_macros.svh"

module lrelu_tb;

  localparam int UNITS  = `LRELU_UNITS;
  localparam int W_IN   = `LRELU_W_IN;
  localparam int W_OUT  = `LRELU_W_OUT;
  localparam int DEPTH  = `LRELU_DEPTH;
  localparam int LAT    = `LRELU_LATENCY;
  localparam int BEATS  = 200;  // data beats per phase
  // up to ~2.5 cycles a beat over four data phases, then doubled
  localparam int MAX_CYCLES = 2 * (4 * BEATS * 5 / 2);

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     clken;
  logic                     s_valid;
  logic [UNITS*W_IN-1:0]    s_data;
  logic [`LRELU_W_TAG:0]    s_user;
  logic                     m_valid;
  logic [UNITS*W_OUT-1:0]   m_data;
  logic [`LRELU_W_TAG-1:0]  m_user;
  logic                     cfg_valid;
  logic [`LRELU_W_CFG-1:0]  cfg_data;
  logic                     cfg_restart;

  // reference model state
  logic [31:0] lfsr = 32'd71779;
  logic        stall_en = 1'b0;
  string       test_name = "reset";
  int          a_mdl [DEPTH];
  int          b_mdl [DEPTH];
  int          d_mdl;
  int          ch_idx = 0;    // entry the next beat reads

  logic [UNITS*W_OUT-1:0]  exp_data [$];
  logic [`LRELU_W_TAG-1:0] exp_tag  [$];
  int                      exp_edge [$];  // enabled edge that took the beat

  int cycles    = 0;
  int edges     = 0;
  int rst_edges = 0;
  int beats_in  = 0;

  always #2 clk = ~clk;

  lrelu_engine i_dut (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .s_valid     (s_valid),
    .s_data      (s_data),
    .s_user      (s_user),
    .m_valid     (m_valid),
    .m_data      (m_data),
    .m_user      (m_user),
    .cfg_valid   (cfg_valid),
    .cfg_data    (cfg_data),
    .cfg_restart (cfg_restart)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  // one Galois step for each bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Q8.8 product floored back to integer scale
  function automatic int scale_q8(input int v, input int k);
    longint p;
    p = longint'(v) * longint'(k);
    return int'(p >>> `LRELU_FRAC);
  endfunction

  function automatic logic [W_OUT-1:0] clamp8(input int v);
    if (v > 127)
      return 8'h7f;
    if (v < -128)
      return 8'h80;
    return W_OUT'(v);
  endfunction

  function automatic logic [W_OUT-1:0] lane_result(
    input int x, input int a, input int b, input int d, input logic leaky
  );
    int y1;
    int c;
    y1 = scale_q8(x, a) + b;
    c  = (leaky && y1 < 0) ? `LRELU_ALPHA : `LRELU_ONE;  // slope below zero
    return clamp8(scale_q8(y1, c) + d);
  endfunction

  // no output beat before the first input beat
  assert property (@(posedge clk) disable iff (rst) (beats_in == 0) |-> !m_valid)
    else fail_run("m_valid was raised before any input beat");

  always @(posedge clk) begin : check_outputs
    logic                   due;
    logic [UNITS*W_OUT-1:0] exp_word;
    int                     x;
    cycles++;
    if (cycles > MAX_CYCLES)
      fail_run($sformatf("timeout, run did not finish within %0d cycles", MAX_CYCLES));
    if (rst) begin
      if (rst_edges > 0)
        assert (!m_valid) else fail_run("m_valid was high while reset was asserted");
      rst_edges++;
    end else if (clken) begin
      edges++;
      due = exp_edge.size() > 0 && exp_edge[0] + LAT == edges;
      assert (m_valid == due)
        else fail_run($sformatf("ERR %s m_valid expected %0b actual %0b",
                                test_name, due, m_valid));
      if (m_valid) begin
        assert (m_data == exp_data[0])
          else fail_run($sformatf("ERR %s m_data expected %h actual %h",
                                  test_name, exp_data[0], m_data));
        assert (m_user == exp_tag[0])
          else fail_run($sformatf("ERR %s m_user expected %0d actual %0d",
                                  test_name, exp_tag[0], m_user));
        void'(exp_data.pop_front());
        void'(exp_tag.pop_front());
        void'(exp_edge.pop_front());
      end
      if (s_valid) begin
        for (int u = 0; u < UNITS; u++) begin
          x = int'($signed(s_data[u*W_IN +: W_IN]));
          exp_word[u*W_OUT +: W_OUT] = lane_result(x, a_mdl[ch_idx], b_mdl[ch_idx],
                                                   d_mdl, s_user[0]);
        end
        exp_data.push_back(exp_word);
        exp_tag.push_back(s_user[`LRELU_W_TAG:1]);
        exp_edge.push_back(edges);
        ch_idx = (ch_idx + 1) % DEPTH;  // all lanes share the entry
        beats_in++;
      end
    end
  end

  // holds the inputs until an enabled edge takes them
  task automatic drive(
    input logic cv, input logic [`LRELU_W_CFG-1:0] cd, input logic cr,
    input logic sv, input logic [UNITS*W_IN-1:0] sd, input logic [`LRELU_W_TAG:0] su
  );
    do begin
      @(negedge clk);
      clken       = stall_en ? (take_bits(2) != 0) : 1'b1;  // about one in four frozen
      cfg_valid   = cv;
      cfg_data    = cd;
      cfg_restart = cr;
      s_valid     = sv;
      s_data      = sd;
      s_user      = su;
    end while (!clken);
  endtask

  task automatic idle();
    drive(1'b0, '0, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic send_cfg(input int w);
    drive(1'b1, `LRELU_W_CFG'(w), 1'b0, 1'b0, '0, '0);
  endtask

  // D, then the A entries, then the B entries
  task automatic load_config();
    send_cfg(d_mdl);
    for (int i = 0; i < DEPTH; i++)
      send_cfg(a_mdl[i]);
    for (int i = 0; i < DEPTH; i++)
      send_cfg(b_mdl[i]);
    repeat (3) idle();  // last write lands before the first read
  endtask

  task automatic send_beat(input logic pos_only, input logic flag_random);
    logic [UNITS*W_IN-1:0] sd;
    logic [W_IN-1:0]       w;
    logic                  flag;
    for (int u = 0; u < UNITS; u++) begin
      w = W_IN'(take_bits(W_IN));
      if (pos_only)
        w[W_IN-1] = 1'b0;
      w = W_IN'($signed(w) >>> take_bits(3));  // spread the magnitudes
      sd[u*W_IN +: W_IN] = w;
    end
    flag = flag_random ? 1'(take_bits(1)) : 1'b1;
    drive(1'b0, '0, 1'b0, 1'b1, sd, {`LRELU_W_TAG'(take_bits(`LRELU_W_TAG)), flag});
  endtask

  task automatic run_data(input logic pos_only, input logic flag_random, input logic gaps);
    for (int n = 0; n < BEATS; n++) begin
      if (gaps && take_bits(1) != 0)
        idle();
      send_beat(pos_only, flag_random);
    end
  endtask

  task automatic drain();
    while (exp_edge.size() != 0)
      idle();
    repeat (2) idle();
  endtask

  initial begin
    rst         = 1'b1;
    clken       = 1'b1;
    s_valid     = 1'b0;
    s_data      = '0;
    s_user      = '0;
    cfg_valid   = 1'b0;
    cfg_data    = '0;
    cfg_restart = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    repeat (4) idle();

    test_name = "positive";
    d_mdl = 5;
    a_mdl = '{256, 128, 512};
    b_mdl = '{10, -20, 40};
    load_config();
    run_data(1'b1, 1'b0, 1'b0);
    drain();

    test_name = "leaky";
    d_mdl = -3;
    a_mdl = '{300, 64, 200};
    b_mdl = '{-50, 30, 0};
    load_config();
    run_data(1'b0, 1'b1, 1'b0);
    drain();

    test_name = "stall";
    stall_en = 1'b1;
    d_mdl = 12;
    a_mdl = '{-256, 90, 400};
    b_mdl = '{7, -7, 1000};
    load_config();
    run_data(1'b0, 1'b1, 1'b1);
    drain();

    test_name = "reconfig";
    repeat (4) send_beat(1'b0, 1'b1);  // leave the read pointer mid-cycle
    drain();
    send_cfg(16'h1234);  // abandoned load
    send_cfg(16'h0bad);
    drive(1'b0, '0, 1'b1, 1'b0, '0, '0);
    ch_idx = 0;
    d_mdl = -40;
    a_mdl = '{512, 256, 20};
    b_mdl = '{-300, 100, 60};
    load_config();
    run_data(1'b0, 1'b1, 1'b1);
    drain();

    $display("Regression passed");
    $finish;
  end

endmodule
